// ==== source/rv_pkg.sv ====
// ######################################
// RV32I execution core shared definitions
// Widths, opcodes, ALU operations and the
// bus address map
// ######################################

package rv_pkg;

	localparam int xlen  = 32;
	localparam int adr_w = 8;

	typedef logic [4:0] reg_idx_t;

	// ######################################
	// ALU operations
	// ######################################
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_t;

	// Major opcodes of the supported groups
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// Register i sits at byte address base + 4*i on the slave port
	localparam logic [adr_w-1:0] addr_exec     = 8'h00;
	localparam logic [adr_w-1:0] addr_reg_base = 8'h80;

endpackage

// ==== source/rv_regfile.sv ====
// ######################################
// Register file with two combinational
// read ports, one write port and x0 tied
// to zero
// ######################################
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; #(
	parameter int reg_count = 32
) (
	input  logic            clk,
	input  logic            rst_n,

	input  logic            wr_en,
	input  reg_idx_t        wr_idx,
	input  logic [xlen-1:0] wr_data,

	input  reg_idx_t        rd1_idx,
	input  reg_idx_t        rd2_idx,
	output logic [xlen-1:0] rd1_data,
	output logic [xlen-1:0] rd2_data
);

	// Entry zero is not stored
	logic [xlen-1:0] regs [1:reg_count-1];

	function automatic logic [xlen-1:0] read_reg(input reg_idx_t idx);
		logic [xlen-1:0] val;
		val = '0;
		if (idx != '0 && idx < reg_count) begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0 && wr_idx < reg_count) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Old value is returned while a write to the same index is pending
	always_comb begin
		rd1_data = read_reg(rd1_idx);
		rd2_data = read_reg(rd2_idx);
	end

endmodule

// ==== source/rv_decoder.sv ====
// ######################################
// Instruction decoder for the OP, OP-IMM
// and LUI groups of RV32I
// ######################################
`timescale 1ns/100ps

module rv_decoder import rv_pkg::*; #(
	parameter int reg_count = 32
) (
	input  logic [xlen-1:0] instr,

	output reg_idx_t        rs1,
	output reg_idx_t        rs2,
	output reg_idx_t        rd,

	output logic [xlen-1:0] imm,
	output logic            use_imm,
	output alu_op_t         alu_op,
	output logic            illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// funct3 picks the operation, alt selects sub or sra
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			f3_add_sub: op = alt ? alu_sub : alu_add;
			f3_sll:     op = alu_sll;
			f3_slt:     op = alu_slt;
			f3_sltu:    op = alu_sltu;
			f3_xor:     op = alu_xor;
			f3_srl_sra: op = alt ? alu_sra : alu_srl;
			f3_or:      op = alu_or;
			default:    op = alu_and;
		endcase
		return op;
	endfunction

	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	always_comb begin
		imm     = {{(xlen-12){instr[31]}}, instr[31:20]};
		use_imm = 1'b1;
		alu_op  = alu_add;
		illegal = 1'b0;

		case (opcode)
			opc_op: begin
				use_imm = 1'b0;
				alu_op  = arith_op(funct3, funct7[5]);
				illegal = (rd >= reg_count) || (rs1 >= reg_count) || (rs2 >= reg_count);
				// Only add/sub and srl/sra have an alternate encoding
				if (funct7 != f7_base) begin
					if (funct7 != f7_alt || (funct3 != f3_add_sub && funct3 != f3_srl_sra)) begin
						illegal = 1'b1;
					end
				end
			end

			opc_op_imm: begin
				// Bit 30 belongs to the immediate except on the right shifts
				alu_op  = arith_op(funct3, funct7[5] & (funct3 == f3_srl_sra));
				illegal = (rd >= reg_count) || (rs1 >= reg_count);
				if (funct3 == f3_sll && funct7 != f7_base) begin
					illegal = 1'b1;
				end
				if (funct3 == f3_srl_sra && funct7 != f7_base && funct7 != f7_alt) begin
					illegal = 1'b1;
				end
			end

			opc_lui: begin
				imm     = {instr[31:12], 12'b0};
				alu_op  = alu_pass_b;
				illegal = (rd >= reg_count);
			end

			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== source/rv_alu.sv ====
// ######################################
// Integer ALU for arithmetic, logic,
// compare and shift operations
// ######################################
`timescale 1ns/100ps

module rv_alu import rv_pkg::*; (
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  alu_op_t         op,
	output logic [xlen-1:0] result
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// Shifts use only the low five bits of the second operand
	assign shamt       = b[4:0];
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			alu_add: begin
				result = a + b;
			end
			alu_sub: begin
				result = a - b;
			end
			alu_sll: begin
				result = a << shamt;
			end
			alu_slt: begin
				result = {{(xlen-1){1'b0}}, lt_signed};
			end
			alu_sltu: begin
				result = {{(xlen-1){1'b0}}, lt_unsigned};
			end
			alu_xor: begin
				result = a ^ b;
			end
			alu_srl: begin
				result = a >> shamt;
			end
			alu_sra: begin
				result = $unsigned($signed(a) >>> shamt);
			end
			alu_or: begin
				result = a | b;
			end
			alu_and: begin
				result = a & b;
			end
			// LUI passes its immediate through
			default: begin
				result = b;
			end
		endcase
	end

endmodule

// ==== source/rv_wb_port.sv ====
// ######################################
// Wishbone classic slave of the core
// Decodes the address map, answers with a
// registered ack or err and steers the
// register file ports
// ######################################
`timescale 1ns/100ps

module rv_wb_port import rv_pkg::*; #(
	parameter int reg_count = 32
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  logic [adr_w-1:0] adr,
	input  logic [xlen-1:0]  dat_w,
	output logic [xlen-1:0]  dat_r,
	output logic             ack,
	output logic             err,

	input  logic             illegal,
	input  reg_idx_t         dec_rd,
	input  logic [xlen-1:0]  alu_result,
	input  reg_idx_t         rs1_dec,
	input  logic [xlen-1:0]  rd1_data,

	output reg_idx_t         rd1_idx,
	output logic             reg_wr_en,
	output reg_idx_t         reg_wr_idx,
	output logic [xlen-1:0]  reg_wr_data
);

	logic             req;
	logic             is_exec;
	logic             is_reg;
	logic             bad;
	logic [adr_w-1:0] reg_off;
	reg_idx_t         adr_idx;

	// ######################################
	// Address decode and error decision
	// ######################################
	assign reg_off = adr - addr_reg_base;
	assign adr_idx = reg_off[6:2];
	assign is_exec = (adr == addr_exec);
	assign is_reg  = (adr >= addr_reg_base) && (adr[1:0] == 2'b00);

	assign bad = is_exec ? (~we | illegal) : is_reg ? (adr_idx >= reg_count) : 1'b1;

	// A new request is taken only once the previous response is gone
	assign req = cyc & stb & ~ack & ~err;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
			err <= 1'b0;
		end else begin
			ack <= req & ~bad;
			err <= req & bad;
		end
	end

	// Register writes land at the edge that ends the ack cycle
	assign reg_wr_en   = ack & we;
	assign reg_wr_idx  = is_exec ? dec_rd : adr_idx;
	assign reg_wr_data = is_exec ? alu_result : dat_w;

	assign rd1_idx = we ? rs1_dec : adr_idx;
	assign dat_r   = rd1_data;

endmodule

// ==== source/rv_exec_top.sv ====
// ######################################
// RV32I execution core top level
// Bus port, decoder, ALU and register file
// ######################################
`timescale 1ns/100ps

module rv_exec_top import rv_pkg::*; #(
	parameter int reg_count = 32
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  logic [adr_w-1:0] adr,
	input  logic [xlen-1:0]  dat_w,
	output logic [xlen-1:0]  dat_r,
	output logic             ack,
	output logic             err
);

	reg_idx_t        rs1;
	reg_idx_t        rs2;
	reg_idx_t        rd;
	logic [xlen-1:0] imm;
	logic            use_imm;
	alu_op_t         alu_op;
	logic            illegal;

	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_result;

	reg_idx_t        rd1_idx;
	logic [xlen-1:0] rd1_data;
	logic [xlen-1:0] rd2_data;
	logic            reg_wr_en;
	reg_idx_t        reg_wr_idx;
	logic [xlen-1:0] reg_wr_data;

	rv_wb_port #(
		.reg_count(reg_count)
	) u_wb_port (
		.clk(clk), .rst_n(rst_n),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
		.dat_r(dat_r), .ack(ack), .err(err),
		.illegal(illegal), .dec_rd(rd), .alu_result(alu_result),
		.rs1_dec(rs1), .rd1_data(rd1_data), .rd1_idx(rd1_idx),
		.reg_wr_en(reg_wr_en), .reg_wr_idx(reg_wr_idx), .reg_wr_data(reg_wr_data)
	);

	// The instruction word comes straight from the bus data
	rv_decoder #(
		.reg_count(reg_count)
	) u_decoder (
		.instr(dat_w), .rs1(rs1), .rs2(rs2), .rd(rd),
		.imm(imm), .use_imm(use_imm), .alu_op(alu_op), .illegal(illegal)
	);

	assign alu_b = use_imm ? imm : rd2_data;

	rv_alu u_alu (
		.a(rd1_data), .b(alu_b), .op(alu_op), .result(alu_result)
	);

	rv_regfile #(
		.reg_count(reg_count)
	) u_regfile (
		.clk(clk), .rst_n(rst_n),
		.wr_en(reg_wr_en), .wr_idx(reg_wr_idx), .wr_data(reg_wr_data),
		.rd1_idx(rd1_idx), .rd2_idx(rs2), .rd1_data(rd1_data), .rd2_data(rd2_data)
	);

endmodule

// ==== test/rv_ref_model.svh ====
// ######################################
// Reference model of the register array
// and of RV32I OP, OP-IMM and LUI results
// ######################################
`ifndef rv_ref_model_svh
`define rv_ref_model_svh

logic [31:0] model_regs [0:31];

function automatic void model_write(input logic [4:0] idx, input logic [31:0] val);
	if (idx != 5'd0) begin
		model_regs[idx] = val;
	end
endfunction

// Result of one instruction on the current model state
function automatic logic [31:0] model_result(input logic [31:0] instr);
	logic [31:0] a;
	logic [31:0] b;
	logic [4:0]  sh;
	logic        alt;
	logic [31:0] res;
	a   = model_regs[instr[19:15]];
	b   = (instr[6:0] == 7'h33) ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
	sh  = b[4:0];
	alt = instr[30];
	case (instr[14:12])
		3'd0: res = (alt && instr[6:0] == 7'h33) ? a - b : a + b;
		3'd1: res = a << sh;
		3'd2: res = {31'd0, $signed(a) < $signed(b)};
		3'd3: res = {31'd0, a < b};
		3'd4: res = a ^ b;
		3'd5: res = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
		3'd6: res = a | b;
		default: res = a & b;
	endcase
	if (instr[6:0] == 7'h37) begin
		res = {instr[31:12], 12'h000};
	end
	return res;
endfunction

`endif

// ==== test/tb_rv_exec.sv ====
// ######################################
// Testbench of the RV32I execution core
// Random bus traffic checked against a
// register and instruction model
// ######################################
`timescale 1ns/100ps

module tb_rv_exec;

	localparam int reg_count = 32;
	localparam int max_wait  = 16;

	logic        clk;
	logic        rst_n;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [7:0]  adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic        ack;
	logic        err;

	integer      seed;
	int          error_count;
	int          check_count;
	string       test_name;
	logic [31:0] r;
	logic [31:0] instr;
	logic [7:0]  bad_adr;

	`include "rv_ref_model.svh"

	rv_exec_top #(
		.reg_count(reg_count)
	) u_dut (
		.clk(clk), .rst_n(rst_n),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
		.dat_r(dat_r), .ack(ack), .err(err)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [7:0] reg_addr(input logic [4:0] idx);
		return {1'b1, idx, 2'b00};
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("[ERROR] %s %s: expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("No bus response during %s within %0d cycles", what, max_wait);
		$display("Test failures found");
		$finish;
	endtask

	// Runs one Wishbone classic transaction and samples the outputs on the falling edge
	task automatic bus_cycle(input logic wr, input logic [7:0] a, input logic [31:0] d,
			output logic [31:0] rdata, output logic got_err);
		int   cycles;
		logic seen;
		cycles  = 0;
		seen    = 1'b0;
		rdata   = '0;
		got_err = 1'b0;
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= wr;
		adr   <= a;
		dat_w <= d;
		while (!seen && cycles < max_wait) begin
			@(negedge clk);
			cycles++;
			assert (!(ack && err)) else begin
				error_count++;
				$display("In %s ack and err were high in the same cycle", test_name);
			end
			if (ack || err) begin
				seen    = 1'b1;
				rdata   = dat_r;
				got_err = err;
			end
		end
		if (!seen) begin
			stop_on_timeout(test_name);
		end else begin
			// The strobe is sampled one edge after it is driven
			check_value("response latency", 32'd2, cycles);
			@(posedge clk);
			cyc <= 1'b0;
			stb <= 1'b0;
			we  <= 1'b0;
			@(negedge clk);
			assert (!ack && !err) else begin
				error_count++;
				$display("In %s the response lasted more than one cycle", test_name);
			end
		end
	endtask

	task automatic bus_write(input logic [7:0] a, input logic [31:0] d, output logic got_err);
		logic [31:0] unused;
		bus_cycle(1'b1, a, d, unused, got_err);
	endtask

	task automatic bus_read(input logic [7:0] a, output logic [31:0] d, output logic got_err);
		bus_cycle(1'b0, a, 32'd0, d, got_err);
	endtask

	task automatic read_and_compare(input logic [4:0] idx);
		logic [31:0] d;
		logic        e;
		bus_read(reg_addr(idx), d, e);
		check_value("read err", 32'd0, e);
		check_value($sformatf("x%0d", idx), model_regs[idx], d);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < reg_count; i++) begin
			read_and_compare(i[4:0]);
		end
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
		logic e;
		bus_write(reg_addr(idx), val, e);
		check_value("write err", 32'd0, e);
		model_write(idx, val);
	endtask

	task automatic seed_regs();
		for (int i = 1; i < reg_count; i++) begin
			write_reg(i[4:0], $random(seed));
		end
	endtask

	task automatic run_instr(input logic [31:0] ins);
		logic [31:0] expected;
		logic        e;
		expected = model_result(ins);
		bus_write(8'h00, ins, e);
		check_value($sformatf("exec err %h", ins), 32'd0, e);
		model_write(ins[11:7], expected);
		read_and_compare(ins[11:7]);
	endtask

	task automatic expect_error(input logic wr, input logic [7:0] a, input logic [31:0] d);
		logic [31:0] unused;
		logic        e;
		bus_cycle(wr, a, d, unused, e);
		check_value($sformatf("err at adr %h data %h", a, d), 32'd1, e);
	endtask

	initial begin
		seed        = 95452;
		error_count = 0;
		check_count = 0;
		test_name   = "reset";
		rst_n       = 1'b0;
		cyc         = 1'b0;
		stb         = 1'b0;
		we          = 1'b0;
		adr         = '0;
		dat_w       = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "after_reset";
		check_all_regs();

		test_name = "direct_write";
		write_reg(5'd0, 32'hffff_ffff);
		read_and_compare(5'd0);
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			write_reg(r[4:0], $random(seed));
			read_and_compare(r[4:0]);
		end
		check_all_regs();

		test_name = "op";
		seed_regs();
		for (int i = 0; i < 200; i++) begin
			r     = $random(seed);
			instr = {7'h00, r[24:7], 7'h33};
			if (r[14:12] == 3'd0 || r[14:12] == 3'd5) begin
				instr[30] = r[30];
			end
			run_instr(instr);
		end
		check_all_regs();

		test_name = "op_imm";
		seed_regs();
		for (int i = 0; i < 192; i++) begin
			r = $random(seed);
			// Sweep every shift amount of slli, srli and srai first
			if (i < 32) begin
				instr = {7'h00, i[4:0], r[19:15], 3'd1, r[11:7], 7'h13};
			end else if (i < 64) begin
				instr = {7'h00, i[4:0], r[19:15], 3'd5, r[11:7], 7'h13};
			end else if (i < 96) begin
				instr = {7'h20, i[4:0], r[19:15], 3'd5, r[11:7], 7'h13};
			end else if (r[2:0] == 3'd0) begin
				instr = {r[31:12], r[11:7], 7'h37};
			end else begin
				instr = {r[31:12], r[11:7], 7'h13};
				if (r[14:12] == 3'd1) begin
					instr[31:25] = 7'h00;
				end
				if (r[14:12] == 3'd5) begin
					instr[31:25] = {1'b0, r[30], 5'd0};
				end
			end
			run_instr(instr);
		end
		check_all_regs();

		test_name = "error";
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			if (r[6:0] == 7'h33 || r[6:0] == 7'h13 || r[6:0] == 7'h37) begin
				r[6:0] = 7'h63;
			end
			expect_error(1'b1, 8'h00, r);
			r     = $random(seed);
			instr = {r[31:7], 7'h33};
			if (r[31:25] == 7'h00 || r[31:25] == 7'h20) begin
				instr[31:25] = 7'h41;
			end
			expect_error(1'b1, 8'h00, instr);
			expect_error(1'b1, 8'h00, {7'h20, r[24:15], 3'd1, r[11:7], 7'h13});
			expect_error(1'b0, 8'h00, r);
			bad_adr = {1'b0, r[6:0]};
			if (bad_adr == 8'h00) begin
				bad_adr = 8'h04;
			end
			expect_error(r[8], bad_adr, r);
			expect_error(r[9], {1'b1, r[6:2], (r[1:0] == 2'b00) ? 2'b10 : r[1:0]}, r);
		end
		check_all_regs();

		$display("Finished %0d checks with %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+test
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_wb_port.sv
source/rv_exec_top.sv
test/tb_rv_exec.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RV32I execution core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_rv_exec --Mdir obj_dir -o sim_rv_exec

./obj_dir/sim_rv_exec > sim.log
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation finished without failures"
